//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_cpri_ctrl
FILELIST  ?= sim.f

PASS := Testbench passed
BIN  := obj_dir/V$(TOP)
SRCS := $(wildcard hdl/*.sv bench/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf obj_dir

//--- bench/cpu_api.sv
`default_nettype none

`include "cpri_config.svh"

module cpu_api (
   input  wire logic                 clk,
   input  wire logic                 ack,
   input  wire cpri_pkg::hdlc_word_t din,
   output cpri_pkg::reg_addr_e       adr,
   output cpri_pkg::hdlc_word_t      dout,
   output logic                      en_wr,
   output logic                      en_rd
);
   import cpri_pkg::*;

   // bus idles with both enables low
   initial
   begin
      adr   = REG_CTRL;
      dout  = '0;
      en_wr = 1'b0;
      en_rd = 1'b0;
   end

   ////////////////////////////////////////////////////////////////////////////
   // one request per call, all pins move on the falling edge
   ////////////////////////////////////////////////////////////////////////////

   task automatic bus_cycle(input logic write, input logic [`CPRI_ADR_W-1:0] a,
                            input hdlc_word_t d, output hdlc_word_t q);
      @(negedge clk);
      adr   = reg_addr_e'(a);
      dout  = d;
      en_wr = write;
      en_rd = !write;
      // ack stays high while the fifo holds the request off
      do
         @(negedge clk);
      while (ack);
      // read data is valid while ack is low
      q     = din;
      en_wr = 1'b0;
      en_rd = 1'b0;
      while (!ack)
         @(negedge clk);
   endtask

   task automatic wr(input logic [`CPRI_ADR_W-1:0] a, input hdlc_word_t d);
      hdlc_word_t unused_q;
      bus_cycle(1'b1, a, d, unused_q);
   endtask

   task automatic rd(input logic [`CPRI_ADR_W-1:0] a, output hdlc_word_t q);
      bus_cycle(1'b0, a, '0, q);
   endtask

   // queues one word for one frame
   task automatic hdlc_wr(input hdlc_word_t d);
      wr(REG_TX_DATA, d);
   endtask

   // pops a word, then fetches the round trip delay latched with it
   task automatic hdlc_rd(output hdlc_word_t q, output delay_t dly);
      hdlc_word_t raw;
      rd(REG_RX_DATA, q);
      rd(REG_ROUND_DELAY, raw);
      dly = delay_t'(raw);
   endtask

endmodule

`default_nettype wire

//--- bench/tb_cpri_ctrl.sv
`default_nettype none

`include "cpri_config.svh"

module tb_cpri_ctrl;
   import cpri_pkg::*;

   // two flags, the data and the most zeros that stuffing can add
   localparam int MAX_BITS = 16 + `CPRI_DATA_W + `CPRI_DATA_W / `HDLC_STUFF_RUN;
   localparam int N_FRAMES = 17;
   localparam int TIMEOUT  = N_FRAMES * (MAX_BITS + 1) * 4 + 5000;

   logic       clk;
   logic       rst;
   reg_addr_e  adr;
   hdlc_word_t dout;
   logic       en_wr;
   logic       en_rd;
   logic       ack;
   hdlc_word_t din;
   logic       hdlc_txd;
   logic       hdlc_rxd;
   logic       force_one;
   logic       ninth_done;
   int         seed;
   int         err_cnt;
   int         fail_cnt;
   hdlc_word_t words [9];

   // loopback where force_one lifts a stretch of the line to corrupt a frame
   assign hdlc_rxd = hdlc_txd | force_one;

   cpri_ctrl_top UUT (
      .clk      (clk),
      .rst      (rst),
      .adr      (adr),
      .dout     (dout),
      .en_wr    (en_wr),
      .en_rd    (en_rd),
      .ack      (ack),
      .din      (din),
      .hdlc_txd (hdlc_txd),
      .hdlc_rxd (hdlc_rxd)
   );

   cpu_api bus (
      .clk   (clk),
      .ack   (ack),
      .din   (din),
      .adr   (adr),
      .dout  (dout),
      .en_wr (en_wr),
      .en_rd (en_rd)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #2 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////////

   // frame bits in line order from the opening flag to the closing flag
   function automatic int hdlc_encode(input hdlc_word_t w, output logic [MAX_BITS-1:0] seq);
      logic [7:0] flag;
      int         n;
      int         run;
      flag = `HDLC_FLAG;
      seq  = '1;
      n    = 0;
      run  = 0;
      for (int i = 0; i < 8; i++)
      begin
         seq[n] = flag[i];
         n++;
      end
      for (int i = 0; i < `CPRI_DATA_W; i++)
      begin
         seq[n] = w[i];
         n++;
         run = w[i] ? run + 1 : 0;
         // zero after five ones even behind the last data bit
         if (run == `HDLC_STUFF_RUN)
         begin
            seq[n] = 1'b0;
            n++;
            run = 0;
         end
      end
      for (int i = 0; i < 8; i++)
      begin
         seq[n] = flag[i];
         n++;
      end
      return n;
   endfunction

   function automatic delay_t expected_delay(input hdlc_word_t w);
      logic [MAX_BITS-1:0] seq;
      return delay_t'(hdlc_encode(w, seq) + 1);
   endfunction

   function automatic status_t make_status(input int tx, input int rx, input logic busy);
      status_t s;
      s          = '0;
      s.tx_count = fifo_cnt_t'(tx);
      s.rx_count = fifo_cnt_t'(rx);
      s.tx_busy  = busy;
      return s;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_word(input string name, input hdlc_word_t got, input hdlc_word_t exp);
      if (got !== exp)
      begin
         $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_status(input status_t got, input status_t exp);
      if (got !== exp)
      begin
         $display("** Error at %0t: REG_STATUS is %h, expected %h", $time, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_delay(input delay_t got, input delay_t exp);
      if (got !== exp)
      begin
         $display("** Error at %0t: REG_ROUND_DELAY is %0d, expected %0d", $time, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic expect_status(input int tx, input int rx, input logic busy);
      hdlc_word_t q;
      bus.rd(REG_STATUS, q);
      check_status(status_t'(q), make_status(tx, rx, busy));
   endtask

   task automatic pop_and_check(input hdlc_word_t exp);
      hdlc_word_t got;
      delay_t     dly;
      bus.hdlc_rd(got, dly);
      check_word("REG_RX_DATA", got, exp);
      check_delay(dly, expected_delay(exp));
   endtask

   // polls until the transmitter is idle with nothing queued
   task automatic wait_tx_idle();
      hdlc_word_t q;
      status_t    st;
      do
      begin
         bus.rd(REG_STATUS, q);
         st = status_t'(q);
      end
      while (st.tx_busy || st.tx_count != 0);
   endtask

   // line monitor where bit 0 is the first falling edge with the line low
   task automatic watch_frame(input hdlc_word_t w);
      logic [MAX_BITS-1:0] seq;
      int                  len;
      len = hdlc_encode(w, seq);
      do
         @(negedge clk);
      while (hdlc_txd !== 1'b0);
      for (int i = 0; i < len; i++)
      begin
         if (i > 0)
            @(negedge clk);
         check_bit("hdlc_txd", hdlc_txd, seq[i]);
      end
      // back to idle after the closing flag
      @(negedge clk);
      check_bit("hdlc_txd", hdlc_txd, 1'b1);
   endtask

   // forces line bits first..last of the next frame to one
   task automatic corrupt_frame(input int first, input int last);
      do
         @(negedge clk);
      while (hdlc_txd !== 1'b0);
      for (int i = 1; i <= last; i++)
      begin
         @(negedge clk);
         if (i == first)
            force_one = 1'b1;
      end
      @(negedge clk);
      force_one = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // scenarios
   ////////////////////////////////////////////////////////////////////////////

   task automatic reset_and_regs();
      hdlc_word_t              w;
      hdlc_word_t              s;
      hdlc_word_t              q;
      logic [`CPRI_ADR_W-1:0] a;
      check_bit("ack", ack, 1'b1);
      check_bit("hdlc_txd", hdlc_txd, 1'b1);
      expect_status(0, 0, 1'b0);
      for (int i = 0; i < 4; i++)
      begin
         s = $random(seed);
         bus.wr(REG_SCRATCH, s);
         bus.rd(REG_SCRATCH, q);
         check_word("REG_SCRATCH", q, s);
         w = $random(seed);
         bus.wr(REG_CTRL, w);
         bus.rd(REG_CTRL, q);
         check_word("REG_CTRL", q, w);
      end
      // writes to read-only and unmapped addresses leave no trace
      bus.wr(REG_STATUS, 32'hFFFF_FFFF);
      bus.wr(`CPRI_ADR_W'(6), 32'hA5A5_A5A5);
      expect_status(0, 0, 1'b0);
      bus.rd(REG_SCRATCH, q);
      check_word("REG_SCRATCH", q, s);
      bus.rd(REG_CTRL, q);
      check_word("REG_CTRL", q, w);
      for (int i = 0; i < 4; i++)
      begin
         a    = $random(seed);
         a[3] = 1'b1;
         bus.rd(a, q);
         check_word("din", q, '0);
      end
      bus.rd(`CPRI_ADR_W'(6), q);
      check_word("din", q, '0);
   endtask

   task automatic line_encoding(input hdlc_word_t w);
      fork
         bus.hdlc_wr(w);
         watch_frame(w);
      join
      pop_and_check(w);
   endtask

   task automatic loopback(input int n);
      for (int i = 0; i < n; i++)
      begin
         words[i] = $random(seed);
         bus.hdlc_wr(words[i]);
      end
      for (int i = 0; i < n; i++)
         pop_and_check(words[i]);
      expect_status(0, 0, 1'b0);
   endtask

   // five forced ones make the next zero look stuffed so 31 data bits remain
   task automatic corrupt_drop();
      fork
         bus.hdlc_wr('0);
         corrupt_frame(8, 12);
      join
      wait_tx_idle();
      expect_status(0, 0, 1'b0);
   endtask

   task automatic back_pressure();
      bus.wr(REG_CTRL, '0);
      for (int i = 0; i < 8; i++)
      begin
         words[i] = $random(seed);
         bus.hdlc_wr(words[i]);
      end
      expect_status(8, 0, 1'b0);
      words[8]   = $random(seed);
      ninth_done = 1'b0;
      fork
         begin
            bus.hdlc_wr(words[8]);
            ninth_done = 1'b1;
         end
         begin
            repeat (10)
            begin
               @(negedge clk);
               check_bit("ack", ack, 1'b1);
            end
            if (ninth_done)
            begin
               $display("ninth write to REG_TX_DATA finished while the transmit FIFO was full");
               fail_cnt++;
            end
            // the stalled write owns the bus so the engine enable is forced beside it
            force UUT.hdlc_en = 1'b1;
         end
      join
      bus.wr(REG_CTRL, 32'h1);
      release UUT.hdlc_en;
      // first frame in flight with the ninth word in its slot and nothing received yet
      expect_status(8, 0, 1'b1);
      for (int i = 0; i < 9; i++)
         pop_and_check(words[i]);
      expect_status(0, 0, 1'b0);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence and watchdog
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      seed      = 36;
      err_cnt   = 0;
      fail_cnt  = 0;
      force_one = 1'b0;
      rst       = 1'b1;
      repeat (8)
         @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      reset_and_regs();
      bus.wr(REG_CTRL, 32'h1);
      // all ones stuffs six times and the second word stuffs behind its last bit
      line_encoding(32'hFFFF_FFFF);
      line_encoding(32'hF800_0000);
      line_encoding($random(seed));
      loopback(4);
      corrupt_drop();
      back_pressure();
      $display("%0d value errors, %0d other failures", err_cnt, fail_cnt);
      if (err_cnt == 0 && fail_cnt == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

   initial
   begin
      #(TIMEOUT);
      $display("run did not finish within %0d time units", TIMEOUT);
      $display("%0d value errors, %0d other failures", err_cnt, fail_cnt);
      $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- hdl/cpri_ctrl_top.sv
`default_nettype none

module cpri_ctrl_top (
   input  wire logic                 clk,
   input  wire logic                 rst,
   input  wire cpri_pkg::reg_addr_e  adr,
   input  wire cpri_pkg::hdlc_word_t dout,
   input  wire logic                 en_wr,
   input  wire logic                 en_rd,
   output logic                      ack,
   output cpri_pkg::hdlc_word_t      din,
   output logic                      hdlc_txd,
   input  wire logic                 hdlc_rxd
);
   import cpri_pkg::*;

   // transmit queue
   logic       tx_push;
   logic       tx_pop;
   logic       tx_full;
   logic       tx_empty;
   hdlc_word_t tx_word;
   hdlc_word_t tx_head;
   fifo_cnt_t  tx_count;

   // receive queue
   logic       rx_pop;
   logic       rx_empty;
   rx_entry_t  rx_entry_in;
   rx_entry_t  rx_head;
   fifo_cnt_t  rx_count;

   // hdlc engine
   logic       hdlc_en;
   logic       tx_start;
   logic       tx_busy;
   logic       word_done;
   hdlc_word_t rx_word;
   delay_t     delay;

   // received word travels with its measured delay
   assign rx_entry_in = '{word: rx_word, delay: delay};

   cpri_regs u_regs (
      .clk       (clk),
      .rst       (rst),
      .adr       (adr),
      .dout      (dout),
      .en_wr     (en_wr),
      .en_rd     (en_rd),
      .ack       (ack),
      .din       (din),
      .tx_push   (tx_push),
      .tx_word   (tx_word),
      .tx_full   (tx_full),
      .tx_count  (tx_count),
      .rx_pop    (rx_pop),
      .rx_entry  (rx_head),
      .rx_empty  (rx_empty),
      .rx_count  (rx_count),
      .hdlc_en   (hdlc_en),
      .tx_start  (tx_start),
      .tx_busy   (tx_busy),
      .word_done (word_done),
      .delay     (delay)
   );

   msg_fifo #(.payload_t(hdlc_word_t)) u_tx_fifo (
      .clk       (clk),
      .rst       (rst),
      .push      (tx_push),
      .push_data (tx_word),
      .pop       (tx_pop),
      .pop_data  (tx_head),
      .full      (tx_full),
      .empty     (tx_empty),
      .count     (tx_count)
   );

   // full is left open, overflow is caught by the fifo assertion
   msg_fifo #(.payload_t(rx_entry_t)) u_rx_fifo (
      .clk       (clk),
      .rst       (rst),
      .push      (word_done),
      .push_data (rx_entry_in),
      .pop       (rx_pop),
      .pop_data  (rx_head),
      .full      (),
      .empty     (rx_empty),
      .count     (rx_count)
   );

   hdlc_tx u_hdlc_tx (
      .clk      (clk),
      .rst      (rst),
      .hdlc_en  (hdlc_en),
      .tx_word  (tx_head),
      .tx_empty (tx_empty),
      .tx_pop   (tx_pop),
      .tx_start (tx_start),
      .tx_busy  (tx_busy),
      .hdlc_txd (hdlc_txd)
   );

   hdlc_rx u_hdlc_rx (
      .clk       (clk),
      .rst       (rst),
      .hdlc_rxd  (hdlc_rxd),
      .word_done (word_done),
      .rx_word   (rx_word)
   );

endmodule

`default_nettype wire

//--- hdl/cpri_pkg.sv
`default_nettype none

`include "cpri_config.svh"

package cpri_pkg;

   // register map of the cpu port, anything else reads zero
   typedef enum logic [`CPRI_ADR_W-1:0] {
      REG_CTRL        = `CPRI_ADR_W'd0,
      REG_SCRATCH     = `CPRI_ADR_W'd1,
      REG_TX_DATA     = `CPRI_ADR_W'd2,
      REG_RX_DATA     = `CPRI_ADR_W'd3,
      REG_STATUS      = `CPRI_ADR_W'd4,
      REG_ROUND_DELAY = `CPRI_ADR_W'd5
   } reg_addr_e;

   // one message word, also the cpu data bus width
   typedef logic [`CPRI_DATA_W-1:0] hdlc_word_t;

   // round trip delay in clock cycles
   typedef logic [`CPRI_DELAY_W-1:0] delay_t;

   // fifo occupancy, needs one value above the depth
   typedef logic [$clog2(`CPRI_FIFO_DEPTH+1)-1:0] fifo_cnt_t;

   // receive fifo entry, word plus the delay measured for it
   typedef struct packed {
      hdlc_word_t word;
      delay_t     delay;
   } rx_entry_t;

   // status register layout, busy flag in bit 0
   typedef struct packed {
      logic [`CPRI_DATA_W-2*$bits(fifo_cnt_t)-2:0] rsvd;
      fifo_cnt_t                                   tx_count;
      fifo_cnt_t                                   rx_count;
      logic                                        tx_busy;
   } status_t;

endpackage

`default_nettype wire

//--- hdl/cpri_regs.sv
`default_nettype none

module cpri_regs (
   input  wire logic                 clk,
   input  wire logic                 rst,
   input  wire cpri_pkg::reg_addr_e  adr,
   input  wire cpri_pkg::hdlc_word_t dout,
   input  wire logic                 en_wr,
   input  wire logic                 en_rd,
   output logic                      ack,
   output cpri_pkg::hdlc_word_t      din,
   output logic                      tx_push,
   output cpri_pkg::hdlc_word_t      tx_word,
   input  wire logic                 tx_full,
   input  wire cpri_pkg::fifo_cnt_t  tx_count,
   output logic                      rx_pop,
   input  wire cpri_pkg::rx_entry_t  rx_entry,
   input  wire logic                 rx_empty,
   input  wire cpri_pkg::fifo_cnt_t  rx_count,
   output logic                      hdlc_en,
   input  wire logic                 tx_start,
   input  wire logic                 tx_busy,
   input  wire logic                 word_done,
   output cpri_pkg::delay_t          delay
);
   import cpri_pkg::*;

   // idle waits for a request, done holds ack low until the enable drops
   typedef enum logic {S_IDLE, S_DONE} bus_state_e;

   bus_state_e state;
   hdlc_word_t ctrl_q;
   hdlc_word_t scratch_q;
   hdlc_word_t rd_data;
   delay_t     round_delay;
   status_t    status;
   logic       req;
   logic       stall;
   logic       access;
   logic       timer_run;

   ////////////////////////////////////////////////////////////////////////////
   // handshake
   ////////////////////////////////////////////////////////////////////////////

   assign req = en_wr | en_rd;
   // full tx fifo or empty rx fifo keeps the request pending with ack high
   assign stall  = (en_wr && adr == REG_TX_DATA && tx_full) ||
                   (en_rd && adr == REG_RX_DATA && rx_empty);
   assign access = (state == S_IDLE) && req && !stall;
   assign ack    = state == S_IDLE;

   always_ff @(posedge clk)
   begin
      if (rst)
         state <= S_IDLE;
      else if (state == S_IDLE && access)
         state <= S_DONE;
      else if (state == S_DONE && !req)
         state <= S_IDLE;
   end

   // fifo side effects happen in the single access cycle
   assign tx_push = access && en_wr && adr == REG_TX_DATA;
   assign tx_word = dout;
   assign rx_pop  = access && en_rd && adr == REG_RX_DATA;
   assign hdlc_en = ctrl_q[0];

   ////////////////////////////////////////////////////////////////////////////
   // register file
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ctrl_q      <= '0;
         scratch_q   <= '0;
         round_delay <= '0;
      end
      else
      begin
         if (access && en_wr && adr == REG_CTRL)
            ctrl_q <= dout;
         if (access && en_wr && adr == REG_SCRATCH)
            scratch_q <= dout;
         // delay of the word that leaves the rx fifo
         if (rx_pop)
            round_delay <= rx_entry.delay;
      end
   end

   always_comb
   begin
      status          = '0;
      status.tx_count = tx_count;
      status.rx_count = rx_count;
      status.tx_busy  = tx_busy;
   end

   // read mux, unmapped and write-only addresses give zero
   always_comb
   begin
      case (adr)
         REG_CTRL:        rd_data = ctrl_q;
         REG_SCRATCH:     rd_data = scratch_q;
         REG_RX_DATA:     rd_data = rx_entry.word;
         REG_STATUS:      rd_data = hdlc_word_t'(status);
         REG_ROUND_DELAY: rd_data = hdlc_word_t'(round_delay);
         default:         rd_data = '0;
      endcase
   end

   // read data stays put while ack is low
   always_ff @(posedge clk)
   begin
      if (access && en_rd)
         din <= rd_data;
   end

   ////////////////////////////////////////////////////////////////////////////
   // round trip timer
   ////////////////////////////////////////////////////////////////////////////

   // starts at one with the frame, delay is sampled by the rx fifo on word_done
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         delay     <= '0;
         timer_run <= 1'b0;
      end
      else if (tx_start)
      begin
         delay     <= delay_t'(1);
         timer_run <= 1'b1;
      end
      else
      begin
         if (word_done)
            timer_run <= 1'b0;
         // saturate rather than wrap on a lost frame
         if (timer_run && delay != '1)
            delay <= delay + 1'b1;
      end
   end

   a_one_enable : assert property (@(posedge clk) disable iff (rst) !(en_wr && en_rd));

endmodule

`default_nettype wire

//--- hdl/hdlc_rx.sv
`default_nettype none

`include "cpri_config.svh"

module hdlc_rx (
   input  wire logic            clk,
   input  wire logic            rst,
   input  wire logic            hdlc_rxd,
   output logic                 word_done,
   output cpri_pkg::hdlc_word_t rx_word
);

   localparam logic [7:0] FLAG   = `HDLC_FLAG;
   localparam int         RUN    = `HDLC_STUFF_RUN;
   localparam int         DATA_W = `CPRI_DATA_W;
   // the closing flag leaves its leading zero and five ones in the assembler
   localparam int         ASM_W  = DATA_W + RUN + 1;
   localparam int         CNT_W  = $clog2(ASM_W + 1);

   typedef enum logic {S_HUNT, S_FRAME} rx_state_e;

   rx_state_e        state;
   logic [7:0]       window;
   logic [7:0]       window_nxt;
   logic [2:0]       ones;
   logic [CNT_W-1:0] bit_cnt;
   logic [ASM_W-1:0] asm_q;
   logic             flag_seen;
   logic             drop_bit;
   logic             word_ok;

   // newest line bit enters at the top of the window
   assign window_nxt = {hdlc_rxd, window[7:1]};
   assign flag_seen  = window_nxt == FLAG;
   // after a full run the bit is stuffing, a sixth one or a flag end
   assign drop_bit   = ones >= RUN;
   assign word_ok    = flag_seen && (state == S_FRAME) && bit_cnt == ASM_W;

   // data assembly of payload bits only
   always_ff @(posedge clk)
   begin
      if (state == S_FRAME && !flag_seen && !drop_bit)
         asm_q <= {hdlc_rxd, asm_q[ASM_W-1:1]};
      if (word_ok)
         rx_word <= asm_q[DATA_W-1:0];
   end

   ////////////////////////////////////////////////////////////////////////////
   // flag hunt and frame tracking
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state     <= S_HUNT;
         window    <= '1;
         ones      <= '0;
         bit_cnt   <= '0;
         word_done <= 1'b0;
      end
      else
      begin
         window    <= window_nxt;
         word_done <= word_ok;
         if (flag_seen)
         begin
            // every flag may also open the next frame
            state   <= S_FRAME;
            ones    <= '0;
            bit_cnt <= '0;
         end
         else if (state == S_FRAME)
         begin
            // seventh one in a row is an abort or an idle line
            if (hdlc_rxd && ones == RUN + 1)
               state <= S_HUNT;
            ones <= hdlc_rxd ? ones + 1'b1 : '0;
            // saturate so a long garbage frame never wraps back to a match
            if (!drop_bit && bit_cnt != '1)
               bit_cnt <= bit_cnt + 1'b1;
         end
      end
   end

   // 32 data bits end right where the closing flag remnant begins
   a_word_len : assert property (@(posedge clk) disable iff (rst)
      word_done |-> $past(asm_q[ASM_W-1:DATA_W]) == {{RUN{1'b1}}, 1'b0});

endmodule

`default_nettype wire

//--- hdl/hdlc_tx.sv
`default_nettype none

`include "cpri_config.svh"

module hdlc_tx (
   input  wire logic                 clk,
   input  wire logic                 rst,
   input  wire logic                 hdlc_en,
   input  wire cpri_pkg::hdlc_word_t tx_word,
   input  wire logic                 tx_empty,
   output logic                      tx_pop,
   output logic                      tx_start,
   output logic                      tx_busy,
   output logic                      hdlc_txd
);
   import cpri_pkg::*;

   localparam logic [7:0] FLAG   = `HDLC_FLAG;
   localparam int         RUN    = `HDLC_STUFF_RUN;
   localparam int         DATA_W = `CPRI_DATA_W;
   localparam int         CNT_W  = $clog2(DATA_W + 1);

   typedef enum logic [1:0] {S_IDLE, S_OPEN, S_DATA, S_CLOSE} tx_state_e;

   tx_state_e        state;
   logic [CNT_W-1:0] bit_cnt;
   logic [2:0]       ones;
   hdlc_word_t       shreg;
   logic             launch;
   logic             stuff;
   logic             send_data;

   // start only from idle, so the current frame finishes when hdlc_en clears
   assign launch    = (state == S_IDLE) && hdlc_en && !tx_empty;
   assign tx_pop    = launch;
   assign tx_start  = launch;
   assign tx_busy   = state != S_IDLE;
   // stuffing also covers a run that ends the word, before the closing flag
   assign stuff     = ones == RUN;
   assign send_data = (state == S_DATA) && !stuff && bit_cnt != DATA_W;

   // word goes out lsb first
   always_ff @(posedge clk)
   begin
      if (launch)
         shreg <= tx_word;
      else if (send_data)
         shreg <= shreg >> 1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // line sequencer, one bit per clock on a registered output
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state    <= S_IDLE;
         bit_cnt  <= '0;
         ones     <= '0;
         hdlc_txd <= 1'b1;
      end
      else
      begin
         case (state)
            S_IDLE:
            begin
               hdlc_txd <= launch ? FLAG[0] : 1'b1;
               if (launch)
               begin
                  bit_cnt <= CNT_W'(1);
                  ones    <= '0;
                  state   <= S_OPEN;
               end
            end
            S_OPEN:
            begin
               hdlc_txd <= FLAG[bit_cnt[2:0]];
               bit_cnt  <= (bit_cnt == 7) ? '0 : bit_cnt + 1'b1;
               if (bit_cnt == 7)
                  state <= S_DATA;
            end
            S_DATA:
            begin
               if (stuff)
               begin
                  hdlc_txd <= 1'b0;
                  ones     <= '0;
               end
               else if (bit_cnt == DATA_W)
               begin
                  hdlc_txd <= FLAG[0];
                  bit_cnt  <= CNT_W'(1);
                  state    <= S_CLOSE;
               end
               else
               begin
                  hdlc_txd <= shreg[0];
                  ones     <= shreg[0] ? ones + 1'b1 : '0;
                  bit_cnt  <= bit_cnt + 1'b1;
               end
            end
            S_CLOSE:
            begin
               // one idle bit after the flag keeps the delay sample clean
               hdlc_txd <= (bit_cnt == 8) ? 1'b1 : FLAG[bit_cnt[2:0]];
               bit_cnt  <= (bit_cnt == 8) ? '0 : bit_cnt + 1'b1;
               if (bit_cnt == 8)
                  state <= S_IDLE;
            end
            default:
               state <= S_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hdl/msg_fifo.sv
`default_nettype none

`include "cpri_config.svh"

module msg_fifo #(
   parameter type payload_t = cpri_pkg::hdlc_word_t
) (
   input  wire logic           clk,
   input  wire logic           rst,
   input  wire logic           push,
   input  wire payload_t       push_data,
   input  wire logic           pop,
   output payload_t            pop_data,
   output logic                full,
   output logic                empty,
   output cpri_pkg::fifo_cnt_t count
);

   localparam int DEPTH = `CPRI_FIFO_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   // circular storage, no reset on the payload
   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;

   // head entry shows whenever not empty
   assign pop_data = mem[rd_ptr];
   assign full     = count == DEPTH;
   assign empty    = count == '0;

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= push_data;
   end

   // pointers wrap at the last slot, count follows push and pop
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // writers and readers must honour the flags
   a_no_overflow : assert property (@(posedge clk) disable iff (rst) !(push && full));
   a_no_underflow : assert property (@(posedge clk) disable iff (rst) !(pop && empty));

endmodule

`default_nettype wire

//--- include/cpri_config.svh
`ifndef CPRI_CONFIG_SVH
`define CPRI_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// cpu port and message word
////////////////////////////////////////////////////////////////////////////

// message word width, one hdlc frame carries exactly one word
`define CPRI_DATA_W 32
// register address width seen on the cpu port
`define CPRI_ADR_W 14

// entries per message fifo
`define CPRI_FIFO_DEPTH 8
// round trip delay measurement width
`define CPRI_DELAY_W 16

////////////////////////////////////////////////////////////////////////////
// hdlc line constants
////////////////////////////////////////////////////////////////////////////

// opening and closing flag octet
`define HDLC_FLAG 8'h7E
// ones in a row before the transmitter stuffs a zero
`define HDLC_STUFF_RUN 5

`endif

//--- sim.f
+incdir+include
hdl/cpri_pkg.sv
hdl/msg_fifo.sv
hdl/cpri_regs.sv
hdl/hdlc_tx.sv
hdl/hdlc_rx.sv
hdl/cpri_ctrl_top.sv
bench/cpu_api.sv
bench/tb_cpri_ctrl.sv
